// ==== bench/sorted_list_golden.txt ====
# op test rank meta exp_rank exp_meta exp_count exp_full (test in decimal, the rest in hex)
# I insert, R remove, C count check, E remove on an empty list
C 1 000 00000 000 00000 00 0
I 2 120 10001 000 00000 01 0
I 2 045 10002 000 00000 02 0
I 2 2a0 10003 000 00000 03 0
I 2 045 10004 000 00000 04 0
I 2 3ff 10005 000 00000 05 0
I 2 000 10006 000 00000 06 0
I 2 120 10007 000 00000 07 0
I 2 0f0 10008 000 00000 08 0
I 2 001 10009 000 00000 09 0
I 2 045 1000a 000 00000 0a 0
I 2 300 1000b 000 00000 0b 0
I 2 010 1000c 000 00000 0c 0
I 2 0f0 1000d 000 00000 0d 0
I 2 000 1000e 000 00000 0e 0
I 2 1ab 1000f 000 00000 0f 0
I 2 07c 10010 000 00000 10 0
I 2 2a0 10011 000 00000 11 0
I 2 055 10012 000 00000 12 0
I 2 010 10013 000 00000 13 0
I 2 3ff 10014 000 00000 14 0
I 2 0c8 10015 000 00000 15 0
I 2 120 10016 000 00000 16 0
I 2 033 10017 000 00000 17 0
I 2 001 10018 000 00000 18 0
I 2 200 10019 000 00000 19 0
I 2 07c 1001a 000 00000 1a 0
I 2 150 1001b 000 00000 1b 0
I 2 0aa 1001c 000 00000 1c 0
I 2 045 1001d 000 00000 1d 0
I 2 3a5 1001e 000 00000 1e 1
I 3 002 1001f 000 00000 1e 1
R 4 000 00000 000 10006 1d 0
R 4 000 00000 000 1000e 1c 0
R 4 000 00000 001 10009 1b 0
R 4 000 00000 001 10018 1a 0
R 4 000 00000 010 1000c 19 0
R 4 000 00000 010 10013 18 0
R 4 000 00000 033 10017 17 0
R 4 000 00000 045 10002 16 0
R 4 000 00000 045 10004 15 0
R 4 000 00000 045 1000a 14 0
R 4 000 00000 045 1001d 13 0
R 4 000 00000 055 10012 12 0
R 4 000 00000 07c 10010 11 0
R 4 000 00000 07c 1001a 10 0
R 4 000 00000 0aa 1001c 0f 0
R 4 000 00000 0c8 10015 0e 0
R 4 000 00000 0f0 10008 0d 0
R 4 000 00000 0f0 1000d 0c 0
R 4 000 00000 120 10001 0b 0
R 4 000 00000 120 10007 0a 0
R 4 000 00000 120 10016 09 0
R 4 000 00000 150 1001b 08 0
R 4 000 00000 1ab 1000f 07 0
R 4 000 00000 200 10019 06 0
R 4 000 00000 2a0 10003 05 0
R 4 000 00000 2a0 10011 04 0
R 4 000 00000 300 1000b 03 0
R 4 000 00000 3a5 1001e 02 0
R 4 000 00000 3ff 10005 01 0
R 4 000 00000 3ff 10014 00 0
E 5 000 00000 000 00000 00 0
I 6 080 20001 000 00000 01 0
I 6 040 20002 000 00000 02 0
I 6 080 20003 000 00000 03 0
R 6 000 00000 040 20002 02 0
I 6 020 20004 000 00000 03 0
I 6 080 20005 000 00000 04 0
R 6 000 00000 020 20004 03 0
R 6 000 00000 080 20001 02 0
I 6 010 20006 000 00000 03 0
R 6 000 00000 010 20006 02 0
R 6 000 00000 080 20003 01 0
I 6 3ff 20007 000 00000 02 0
R 6 000 00000 080 20005 01 0
R 6 000 00000 3ff 20007 00 0
C 6 000 00000 000 00000 00 0

// ==== verilog.f ====
common/sl_pkg.sv
source/free_list.sv
source/node_store.sv
source/list_walker.sv
source/list_control_fsm.sv
source/sorted_list_top.sv
bench/sorted_list_assertions.sv
bench/sorted_list_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the sorted list testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
sim_bin="obj_dir/sorted_list_sim"

rm -rf obj_dir "$log_file"

verilator --binary --timing --assert --top-module sorted_list_tb \
	-f verilog.f -o sorted_list_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

"$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "Simulation PASSED" "$log_file"; then
	echo "Run result: pass"
	exit 0
fi
echo "Run result: fail"
exit 1

// ==== bench/sorted_list_tb.sv ====
`timescale 1ns/1ns

module sorted_list_tb;

	localparam int BUSY_TIMEOUT = 400;
	localparam int VALID_TIMEOUT = 50;
	localparam int EMPTY_WINDOW = 20;
	// Polls after the first sample of a remove until valid_out, four cycles after acceptance
	localparam int VALID_DELAY = 3;

	// Character codes seen in the golden file
	localparam int CH_TAB = 9;
	localparam int CH_NL = 10;
	localparam int CH_CR = 13;
	localparam int CH_SPACE = 32;
	localparam int CH_HASH = 35;
	localparam int OP_COUNT = 67;
	localparam int OP_EMPTY = 69;
	localparam int OP_INSERT = 73;
	localparam int OP_REMOVE = 82;

	logic clk;
	logic rst;
	logic insert;
	logic remove;
	sl_pkg::entry_t entry_in;
	sl_pkg::entry_t entry_out;
	logic valid_out;
	sl_pkg::entry_count_t num_entries;
	logic busy;
	logic full;

	int errors;
	int test_errors;
	int tests_run;
	int tests_failed;
	int cur_test;
	logic timed_out;

	sorted_list_top uut
	(
		.clk (clk),
		.rst (rst),
		.insert (insert),
		.remove (remove),
		.entry_in (entry_in),
		.entry_out (entry_out),
		.valid_out (valid_out),
		.num_entries (num_entries),
		.busy (busy),
		.full (full)
	);

	always #2 clk = ~clk;

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_problem(input string what);
		$display("[ERROR] test %0d: %s", cur_test, what);
		errors++;
		test_errors++;
	endtask

	task automatic check_entry(input string name, input sl_pkg::entry_t exp,
		input sl_pkg::entry_t act);
		if (act !== exp)
		begin
			$display("[FAIL] test %0d: %s expected %h, got %h", cur_test, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input sl_pkg::entry_count_t exp,
		input sl_pkg::entry_count_t act);
		if (act !== exp)
		begin
			$display("[FAIL] test %0d: %s expected %h, got %h", cur_test, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] test %0d: %s expected %h, got %h", cur_test, name, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic wait_not_busy();
		int cycles;
		cycles = 0;
		while (busy && cycles < BUSY_TIMEOUT)
		begin
			next_cycle();
			cycles++;
		end
		if (busy)
		begin
			report_problem("timed out waiting for busy to fall");
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_insert(input sl_pkg::entry_t e);
		entry_in = e;
		insert = 1'b1;
		next_cycle();
		insert = 1'b0;
		wait_not_busy();
	endtask

	task automatic apply_remove(output sl_pkg::entry_t got);
		int cycles;
		got = '0;
		remove = 1'b1;
		next_cycle();
		remove = 1'b0;
		cycles = 0;
		while (!valid_out && cycles < VALID_TIMEOUT)
		begin
			next_cycle();
			cycles++;
		end
		if (valid_out)
		begin
			got = entry_out;
			if (cycles != VALID_DELAY)
				report_problem("valid_out did not arrive 4 cycles after the remove");
			// Pulse lasts one cycle and busy drops two cycles after it
			next_cycle();
			check_flag("valid_out", 1'b0, valid_out);
			check_flag("busy", 1'b1, busy);
			next_cycle();
			check_flag("busy", 1'b0, busy);
			wait_not_busy();
		end
		else
		begin
			report_problem("timed out waiting for valid_out after a remove");
			timed_out = 1'b1;
		end
	endtask

	task automatic probe_empty_remove();
		remove = 1'b1;
		next_cycle();
		remove = 1'b0;
		repeat (EMPTY_WINDOW)
		begin
			if (valid_out)
				report_problem("valid_out pulsed after a remove on an empty list");
			next_cycle();
		end
	endtask

	task automatic close_test();
		if (cur_test != 0)
		begin
			tests_run++;
			if (test_errors == 0)
				$display("Test %0d done with no mismatches", cur_test);
			else
			begin
				tests_failed++;
				$display("Test %0d done with %0d problems", cur_test, test_errors);
			end
		end
		test_errors = 0;
	endtask

	initial
	begin
		int fd;
		int ch;
		int n;
		int op;
		int test_num;
		int gap;
		int unsigned seed_value;
		logic done;
		sl_pkg::rank_t g_rank;
		sl_pkg::meta_t g_meta;
		sl_pkg::rank_t exp_rank;
		sl_pkg::meta_t exp_meta;
		sl_pkg::entry_count_t exp_count;
		logic exp_full;
		sl_pkg::entry_t stim;
		sl_pkg::entry_t expect_entry;
		sl_pkg::entry_t got;

		clk = 1'b0;
		rst = 1'b1;
		insert = 1'b0;
		remove = 1'b0;
		entry_in = '0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = 0;
		timed_out = 1'b0;
		done = 1'b0;
		seed_value = $urandom(68);

		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		// Init sweep builds the sentinels and the free list
		wait_not_busy();

		fd = $fopen("bench/sorted_list_golden.txt", "r");
		if (fd == 0)
		begin
			report_problem("could not open the golden file");
			done = 1'b1;
		end
		while (!done && !timed_out)
		begin
			ch = $fgetc(fd);
			if (ch == -1)
				done = 1'b1;
			else if (ch == CH_HASH)
			begin
				while (ch != CH_NL && ch != -1)
					ch = $fgetc(fd);
			end
			else if (ch != CH_SPACE && ch != CH_NL && ch != CH_TAB && ch != CH_CR)
			begin
				op = ch;
				n = $fscanf(fd, "%d %h %h %h %h %h %h", test_num, g_rank, g_meta,
					exp_rank, exp_meta, exp_count, exp_full);
				if (n != 7)
				begin
					report_problem("malformed line in the golden file");
					done = 1'b1;
				end
				else
				begin
					if (test_num != cur_test)
					begin
						close_test();
						cur_test = test_num;
					end
					stim.rank = g_rank;
					stim.meta = g_meta;
					expect_entry.rank = exp_rank;
					expect_entry.meta = exp_meta;
					case (op)
						OP_INSERT:
							apply_insert(stim);
						OP_REMOVE:
						begin
							apply_remove(got);
							if (!timed_out)
								check_entry("entry_out", expect_entry, got);
						end
						OP_EMPTY:
							probe_empty_remove();
						OP_COUNT:
						begin
						end
						default:
							report_problem("unknown operation in the golden file");
					endcase
					if (!timed_out)
					begin
						check_count("num_entries", exp_count, num_entries);
						check_flag("full", exp_full, full);
					end
					gap = $urandom % 4;
					repeat (gap) next_cycle();
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		close_test();
		if (tests_run == 0)
			report_problem("no test ran");

		$display("Tests run: %0d, failed: %0d, total errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== bench/sorted_list_assertions.sv ====
`timescale 1ns/1ns

module sorted_list_assertions
(
	input logic clk,
	input logic rst,
	input logic busy,
	input logic valid_out,
	input logic full,
	input sl_pkg::entry_count_t num_entries
);

	logic init_done;

	// Free list is still filling while init runs
	always_ff @(posedge clk)
	begin
		if (rst)
			init_done <= 1'b0;
		else if (!busy)
			init_done <= 1'b1;
	end

	valid_only_when_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(valid_out) |-> busy)
		else $error("valid_out rose while busy was low");

	count_in_range: assert property (@(posedge clk) disable iff (rst)
		num_entries <= sl_pkg::entry_count_t'(sl_pkg::CAPACITY))
		else $error("num_entries above capacity");

	full_matches_count: assert property (@(posedge clk) disable iff (rst)
		init_done |-> (full == (num_entries == sl_pkg::entry_count_t'(sl_pkg::CAPACITY))))
		else $error("full does not match num_entries");

	count_single_step: assert property (@(posedge clk) disable iff (rst)
		(num_entries == $past(num_entries)) ||
		(num_entries == $past(num_entries) + 1'b1) ||
		(num_entries == $past(num_entries) - 1'b1))
		else $error("num_entries changed by more than one");

endmodule

bind sorted_list_top sorted_list_assertions u_assertions
(
	.clk (clk),
	.rst (rst),
	.busy (busy),
	.valid_out (valid_out),
	.full (full),
	.num_entries (num_entries)
);

// ==== source/sorted_list_top.sv ====
`timescale 1ns/1ns

module sorted_list_top
(
	input logic clk,
	input logic rst,
	input logic insert,
	input logic remove,
	input sl_pkg::entry_t entry_in,
	output sl_pkg::entry_t entry_out,
	output logic valid_out,
	output sl_pkg::entry_count_t num_entries,
	output logic busy,
	output logic full
);

	logic walk_start;
	sl_pkg::rank_t walk_rank;
	logic walk_done;
	sl_pkg::node_idx_t left_node;
	sl_pkg::node_idx_t right_node;
	sl_pkg::node_idx_t rd_a_addr;
	sl_pkg::node_idx_t rd_b_addr;
	sl_pkg::node_t node_a;
	sl_pkg::node_t node_b;
	sl_pkg::node_write_t node_wr;
	logic push;
	logic pop;
	sl_pkg::node_idx_t push_node;
	sl_pkg::node_idx_t free_node;
	logic free_empty;

	// The list is full once no free node remains
	assign full = free_empty;

	list_control_fsm u_ctrl
	(
		.clk (clk),
		.rst (rst),
		.insert (insert),
		.remove (remove),
		.entry_in (entry_in),
		.free_node (free_node),
		.free_empty (free_empty),
		.walk_done (walk_done),
		.left_node (left_node),
		.right_node (right_node),
		.node_b (node_b),
		.walk_start (walk_start),
		.walk_rank (walk_rank),
		.rd_b_addr (rd_b_addr),
		.node_wr (node_wr),
		.push (push),
		.push_node (push_node),
		.pop (pop),
		.entry_out (entry_out),
		.valid_out (valid_out),
		.num_entries (num_entries),
		.busy (busy)
	);

	list_walker u_walker
	(
		.clk (clk),
		.rst (rst),
		.walk_start (walk_start),
		.walk_rank (walk_rank),
		.node_a (node_a),
		.walk_done (walk_done),
		.left_node (left_node),
		.right_node (right_node),
		.rd_a_addr (rd_a_addr)
	);

	node_store u_nodes
	(
		.clk (clk),
		.node_wr (node_wr),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.node_a (node_a),
		.node_b (node_b)
	);

	free_list u_free
	(
		.clk (clk),
		.rst (rst),
		.push (push),
		.push_node (push_node),
		.pop (pop),
		.free_node (free_node),
		.free_empty (free_empty)
	);

endmodule

// ==== source/list_control_fsm.sv ====
`timescale 1ns/1ns

module list_control_fsm
(
	input logic clk,
	input logic rst,
	input logic insert,
	input logic remove,
	input sl_pkg::entry_t entry_in,
	input sl_pkg::node_idx_t free_node,
	input logic free_empty,
	input logic walk_done,
	input sl_pkg::node_idx_t left_node,
	input sl_pkg::node_idx_t right_node,
	input sl_pkg::node_t node_b,
	output logic walk_start,
	output sl_pkg::rank_t walk_rank,
	output sl_pkg::node_idx_t rd_b_addr,
	output sl_pkg::node_write_t node_wr,
	output logic push,
	output sl_pkg::node_idx_t push_node,
	output logic pop,
	output sl_pkg::entry_t entry_out,
	output logic valid_out,
	output sl_pkg::entry_count_t num_entries,
	output logic busy
);

	sl_pkg::ctrl_state_t state;
	sl_pkg::node_idx_t init_cnt;
	sl_pkg::node_idx_t new_node;
	sl_pkg::entry_t new_entry;
	sl_pkg::node_idx_t rmv_node;
	sl_pkg::node_idx_t rmv_left;
	logic finish;
	logic finish_ins;

	// One closing cycle after each operation, while the free list head settles
	assign busy = (state != sl_pkg::IDLE) | finish;
	assign pop = finish & finish_ins;
	assign walk_rank = new_entry.rank;

	always_comb
	begin
		case (state)
			sl_pkg::RMV_READ_NODE: rd_b_addr = node_b.lptr;
			default: rd_b_addr = sl_pkg::TAIL_NODE;
		endcase
	end

	always_comb
	begin
		push = 1'b0;
		push_node = init_cnt;
		if (state == sl_pkg::INIT_FREE)
			push = 1'b1;
		else if (state == sl_pkg::RMV_UNLINK_LEFT)
		begin
			push = 1'b1;
			push_node = rmv_node;
		end
	end

	always_comb
	begin
		node_wr = '0;
		case (state)
			sl_pkg::INIT_ENDS:
			begin
				node_wr.addr = init_cnt;
				node_wr.we_entry = 1'b1;
				node_wr.we_rptr = 1'b1;
				node_wr.we_lptr = 1'b1;
				if (init_cnt == sl_pkg::HEAD_NODE)
				begin
					node_wr.entry = '1;
					node_wr.rptr = sl_pkg::TAIL_NODE;
					node_wr.lptr = sl_pkg::NULL_NODE;
				end
				else
				begin
					node_wr.rptr = sl_pkg::NULL_NODE;
					node_wr.lptr = sl_pkg::HEAD_NODE;
				end
			end
			sl_pkg::INS_LINK_NEW:
			begin
				node_wr.addr = new_node;
				node_wr.entry = new_entry;
				node_wr.rptr = right_node;
				node_wr.lptr = left_node;
				node_wr.we_entry = 1'b1;
				node_wr.we_rptr = 1'b1;
				node_wr.we_lptr = 1'b1;
			end
			sl_pkg::INS_LINK_LEFT:
			begin
				node_wr.addr = left_node;
				node_wr.rptr = new_node;
				node_wr.we_rptr = 1'b1;
			end
			sl_pkg::INS_LINK_RIGHT:
			begin
				node_wr.addr = right_node;
				node_wr.lptr = new_node;
				node_wr.we_lptr = 1'b1;
			end
			sl_pkg::RMV_UNLINK_LEFT:
			begin
				// node_b holds the removed node here
				node_wr.addr = node_b.lptr;
				node_wr.rptr = sl_pkg::TAIL_NODE;
				node_wr.we_rptr = 1'b1;
			end
			sl_pkg::RMV_UNLINK_TAIL:
			begin
				node_wr.addr = sl_pkg::TAIL_NODE;
				node_wr.lptr = rmv_left;
				node_wr.we_lptr = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= sl_pkg::INIT_ENDS;
			init_cnt <= '0;
			walk_start <= 1'b0;
			valid_out <= 1'b0;
			num_entries <= '0;
			finish <= 1'b0;
			finish_ins <= 1'b0;
		end
		else
		begin
			walk_start <= 1'b0;
			valid_out <= 1'b0;
			finish <= 1'b0;
			if (pop)
				num_entries <= num_entries + 1'b1;
			case (state)
				sl_pkg::INIT_ENDS:
				begin
					init_cnt <= init_cnt + 1'b1;
					if (init_cnt == sl_pkg::TAIL_NODE)
						state <= sl_pkg::INIT_FREE;
				end
				sl_pkg::INIT_FREE:
				begin
					init_cnt <= init_cnt + 1'b1;
					if (init_cnt == sl_pkg::node_idx_t'(sl_pkg::NUM_NODES - 1))
						state <= sl_pkg::IDLE;
				end
				sl_pkg::IDLE:
					if (!finish)
					begin
						if (remove && num_entries != '0)
							state <= sl_pkg::RMV_READ_TAIL;
						else if (insert && !free_empty)
						begin
							new_node <= free_node;
							new_entry <= entry_in;
							walk_start <= 1'b1;
							state <= sl_pkg::INS_WAIT_WALK;
						end
					end
				sl_pkg::INS_WAIT_WALK:
					if (walk_done)
						state <= sl_pkg::INS_LINK_NEW;
				sl_pkg::INS_LINK_NEW:
					state <= sl_pkg::INS_LINK_LEFT;
				sl_pkg::INS_LINK_LEFT:
					state <= sl_pkg::INS_LINK_RIGHT;
				sl_pkg::INS_LINK_RIGHT:
				begin
					finish <= 1'b1;
					finish_ins <= 1'b1;
					state <= sl_pkg::IDLE;
				end
				sl_pkg::RMV_READ_TAIL:
					state <= sl_pkg::RMV_READ_NODE;
				sl_pkg::RMV_READ_NODE:
				begin
					rmv_node <= node_b.lptr;
					state <= sl_pkg::RMV_UNLINK_LEFT;
				end
				sl_pkg::RMV_UNLINK_LEFT:
				begin
					entry_out <= node_b.entry;
					valid_out <= 1'b1;
					num_entries <= num_entries - 1'b1;
					rmv_left <= node_b.lptr;
					state <= sl_pkg::RMV_UNLINK_TAIL;
				end
				sl_pkg::RMV_UNLINK_TAIL:
				begin
					finish <= 1'b1;
					finish_ins <= 1'b0;
					state <= sl_pkg::IDLE;
				end
				default:
					state <= sl_pkg::INIT_ENDS;
			endcase
		end
	end

endmodule

// ==== source/list_walker.sv ====
`timescale 1ns/1ns

module list_walker
(
	input logic clk,
	input logic rst,
	input logic walk_start,
	input sl_pkg::rank_t walk_rank,
	input sl_pkg::node_t node_a,
	output logic walk_done,
	output sl_pkg::node_idx_t left_node,
	output sl_pkg::node_idx_t right_node,
	output sl_pkg::node_idx_t rd_a_addr
);

	sl_pkg::walk_state_t state;
	sl_pkg::node_idx_t cur;
	logic stop;

	assign rd_a_addr = cur;

	// Head never stops the walk; tail always does with rank zero
	assign stop = (cur != sl_pkg::HEAD_NODE) && (node_a.entry.rank <= walk_rank);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= sl_pkg::WALK_IDLE;
			cur <= sl_pkg::HEAD_NODE;
			walk_done <= 1'b0;
		end
		else
		begin
			walk_done <= 1'b0;
			case (state)
				sl_pkg::WALK_IDLE:
					if (walk_start)
					begin
						cur <= sl_pkg::HEAD_NODE;
						state <= sl_pkg::WALK_READ;
					end
				sl_pkg::WALK_READ:
					state <= sl_pkg::WALK_CHECK;
				sl_pkg::WALK_CHECK:
					if (stop)
					begin
						right_node <= cur;
						walk_done <= 1'b1;
						state <= sl_pkg::WALK_IDLE;
					end
					else
					begin
						left_node <= cur;
						cur <= node_a.rptr;
						state <= sl_pkg::WALK_READ;
					end
				default:
					state <= sl_pkg::WALK_IDLE;
			endcase
		end
	end

endmodule

// ==== source/node_store.sv ====
`timescale 1ns/1ns

module node_store
(
	input logic clk,
	input sl_pkg::node_write_t node_wr,
	input sl_pkg::node_idx_t rd_a_addr,
	input sl_pkg::node_idx_t rd_b_addr,
	output sl_pkg::node_t node_a,
	output sl_pkg::node_t node_b
);

	sl_pkg::node_t mem [sl_pkg::NUM_NODES];

	// Each field has its own enable so pointer fixups leave the rest intact
	always_ff @(posedge clk)
	begin
		if (node_wr.we_entry)
			mem[node_wr.addr].entry <= node_wr.entry;
		if (node_wr.we_rptr)
			mem[node_wr.addr].rptr <= node_wr.rptr;
		if (node_wr.we_lptr)
			mem[node_wr.addr].lptr <= node_wr.lptr;
	end

	always_ff @(posedge clk)
	begin
		node_a <= mem[rd_a_addr];
		node_b <= mem[rd_b_addr];
	end

endmodule

// ==== source/free_list.sv ====
`timescale 1ns/1ns

module free_list
(
	input logic clk,
	input logic rst,
	input logic push,
	input sl_pkg::node_idx_t push_node,
	input logic pop,
	output sl_pkg::node_idx_t free_node,
	output logic free_empty
);

	sl_pkg::node_idx_t fifo [sl_pkg::NUM_NODES];
	sl_pkg::node_idx_t wr_ptr;
	sl_pkg::node_idx_t rd_ptr;
	logic [sl_pkg::NODE_BITS:0] count;

	// Oldest entry is visible without waiting for a read
	assign free_node = fifo[rd_ptr];
	assign free_empty = (count == '0);

	always_ff @(posedge clk)
	begin
		if (push)
			fifo[wr_ptr] <= push_node;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !free_empty)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !(pop && !free_empty))
				count <= count + 1'b1;
			else if (!push && pop && !free_empty)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== common/sl_pkg.sv ====
package sl_pkg;

	localparam int NODE_BITS = 5;
	localparam int NUM_NODES = 32;
	localparam int CAPACITY = NUM_NODES - 2;
	localparam int RANK_BITS = 10;
	localparam int META_BITS = 20;

	typedef logic [NODE_BITS-1:0] node_idx_t;
	typedef logic [RANK_BITS-1:0] rank_t;
	typedef logic [META_BITS-1:0] meta_t;
	typedef logic [4:0] entry_count_t;

	localparam node_idx_t HEAD_NODE = 5'd0;
	localparam node_idx_t TAIL_NODE = 5'd1;
	localparam node_idx_t NULL_NODE = 5'h1f;

	typedef struct packed {
		rank_t rank;
		meta_t meta;
	} entry_t;

	// One list node as held in the node memory
	typedef struct packed {
		entry_t entry;
		node_idx_t rptr;
		node_idx_t lptr;
	} node_t;

	typedef struct packed {
		node_idx_t addr;
		entry_t entry;
		node_idx_t rptr;
		node_idx_t lptr;
		logic we_entry;
		logic we_rptr;
		logic we_lptr;
	} node_write_t;

	typedef enum logic [3:0] {
		INIT_ENDS,
		INIT_FREE,
		IDLE,
		INS_WAIT_WALK,
		INS_LINK_NEW,
		INS_LINK_LEFT,
		INS_LINK_RIGHT,
		RMV_READ_TAIL,
		RMV_READ_NODE,
		RMV_UNLINK_LEFT,
		RMV_UNLINK_TAIL
	} ctrl_state_t;

	typedef enum logic [1:0] {
		WALK_IDLE,
		WALK_READ,
		WALK_CHECK
	} walk_state_t;

endpackage
